// File: hdl/fdc_mock_cfg.svh
`ifndef FDC_MOCK_CFG_SVH
`define FDC_MOCK_CFG_SVH

// Number of drives on the daisy chain
`define NUM_DRIVES 4

// System clock and the drive timebase it is divided down to
`define CLK_HZ   24000000
`define DRIVE_HZ 3000000

// Timebase enables per byte period, one less than the real spacing
`define SD_BYTE_ENABLES 225
`define DD_BYTE_ENABLES 111

// Length of one data sector including its header and gaps
`define SD_SECTOR_BYTES 325
`define DD_SECTOR_BYTES 351

// Length of the index gap that ends each revolution
`define SD_GAP_BYTES 252
`define DD_GAP_BYTES 132

// Byte position of the header mark and the index pulse
`define MARK_BYTE 8

// Innermost track the head can reach
`define MAX_TRACK 39

`endif

// File: hdl/fdc_drive_pkg.sv
`default_nettype none

package fdc_drive_pkg;

   // Head position, 0 is the outermost track
   typedef logic [5:0] track_t;

   // Sector number, also wide enough for the sectors-per-track field
   typedef logic [4:0] sector_t;

   // Byte position inside a sector or inside the index gap
   typedef logic [8:0] byte_cnt_t;

   // Countdown of timebase enables within one byte period
   typedef logic [7:0] enable_cnt_t;

   // The head passes over the data sectors and then over the index gap
   typedef enum logic {
      scan_sector,
      scan_gap
   } scan_state_t;

endpackage

`default_nettype wire

// File: hdl/fdc_bus_pkg.sv
`default_nettype none

package fdc_bus_pkg;

   typedef logic [3:0]  wb_addr_t;
   typedef logic [15:0] wb_data_t;
   typedef logic [1:0]  drive_idx_t;

   // Low address bit picks the register within a drive's pair
   typedef enum logic {
      reg_mount,
      reg_track
   } reg_sel_t;

   // Layout of the mount register as seen on the bus
   typedef struct packed {
      logic [2:0]             rsvd_hi;
      fdc_drive_pkg::sector_t sps;
      logic [4:0]             rsvd_lo;
      logic                   dbl_density;
      logic                   dbl_sided;
      logic                   mounted;
   } mount_reg_t;

endpackage

`default_nettype wire

// File: hdl/drive_timebase.sv
`default_nettype none

`include "fdc_mock_cfg.svh"

module drive_timebase (
   input  logic clk,
   input  logic arst_n,
   output logic tick
);

   // Wide enough to hold the running sum before the wrap
   localparam int ACC_W = $clog2(`CLK_HZ + `DRIVE_HZ) + 1;

   logic [ACC_W-1:0] acc_q;
   logic [ACC_W-1:0] sum;

   assign sum = acc_q + ACC_W'(`DRIVE_HZ);

   // The remainder stays in the accumulator so the long-term rate is exact
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         acc_q <= '0;
         tick  <= 1'b0;
      end else if (sum >= ACC_W'(`CLK_HZ)) begin
         acc_q <= sum - ACC_W'(`CLK_HZ);
         tick  <= 1'b1;
      end else begin
         acc_q <= sum;
         tick  <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// File: hdl/mock_drive.sv
`default_nettype none

`include "fdc_mock_cfg.svh"

module mock_drive #(
   parameter bit chain_end = 1'b0
) (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   tick,
   input  logic                   sel,
   input  logic                   step,
   input  logic                   dir,
   input  logic                   byte_clk_next,
   input  logic                   header_clk_next,
   input  logic                   ip_next,
   input  logic                   ds_next,
   input  logic                   ready_next,
   input  fdc_drive_pkg::track_t  track_next,
   input  fdc_drive_pkg::sector_t sector_next,
   input  logic                   load,
   input  logic                   load_mounted,
   input  logic                   load_ds,
   input  logic                   load_dd,
   input  fdc_drive_pkg::sector_t load_sps,
   output logic                   ready,
   output logic                   byte_clk,
   output logic                   header_clk,
   output logic                   ip,
   output logic                   ds,
   output fdc_drive_pkg::track_t  track,
   output fdc_drive_pkg::sector_t sector,
   output fdc_drive_pkg::track_t  head_track
);

   fdc_drive_pkg::track_t       track_q;
   fdc_drive_pkg::sector_t      sector_q;
   fdc_drive_pkg::byte_cnt_t    byte_pos_q;
   fdc_drive_pkg::enable_cnt_t  enable_cnt_q;
   fdc_drive_pkg::scan_state_t  state_q;
   logic                        step_q;
   logic                        byte_clk_q;
   logic                        header_clk_q;
   logic                        ip_q;

   fdc_drive_pkg::enable_cnt_t  period;
   fdc_drive_pkg::byte_cnt_t    last_byte;
   fdc_drive_pkg::sector_t      last_sector;

   logic                        byte_clk_tail;
   logic                        header_clk_tail;
   logic                        ip_tail;
   logic                        ds_tail;
   logic                        ready_tail;
   fdc_drive_pkg::track_t       track_tail;
   fdc_drive_pkg::sector_t      sector_tail;

   assign head_track = track_q;

   // Head movement on the falling edge of step, clamped to the disk
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         step_q  <= 1'b0;
         track_q <= '0;
      end else begin
         step_q <= step;
         if (sel && step_q && !step) begin
            if (dir && track_q != fdc_drive_pkg::track_t'(`MAX_TRACK))
               track_q <= track_q + 6'd1;
            else if (!dir && track_q != '0)
               track_q <= track_q - 6'd1;
         end
      end
   end

   assign period = load_dd ? fdc_drive_pkg::enable_cnt_t'(`DD_BYTE_ENABLES)
                           : fdc_drive_pkg::enable_cnt_t'(`SD_BYTE_ENABLES);

   // Byte strobes keep spinning while unmounted, they are only masked
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         enable_cnt_q <= '0;
         byte_clk_q   <= 1'b0;
      end else begin
         byte_clk_q <= 1'b0;
         if (tick) begin
            if (enable_cnt_q != '0) begin
               enable_cnt_q <= enable_cnt_q - 8'd1;
            end else begin
               enable_cnt_q <= period;
               byte_clk_q   <= load_mounted;
            end
         end
      end
   end

   always_comb begin
      if (state_q == fdc_drive_pkg::scan_gap)
         last_byte = load_dd ? fdc_drive_pkg::byte_cnt_t'(`DD_GAP_BYTES - 1)
                             : fdc_drive_pkg::byte_cnt_t'(`SD_GAP_BYTES - 1);
      else
         last_byte = load_dd ? fdc_drive_pkg::byte_cnt_t'(`DD_SECTOR_BYTES - 1)
                             : fdc_drive_pkg::byte_cnt_t'(`SD_SECTOR_BYTES - 1);
   end

   assign last_sector = load_sps - 5'd1;

   // Sector scan, the gap reports sector 0
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state_q      <= fdc_drive_pkg::scan_sector;
         sector_q     <= '0;
         byte_pos_q   <= '0;
         header_clk_q <= 1'b0;
         ip_q         <= 1'b0;
      end else begin
         header_clk_q <= 1'b0;
         ip_q         <= 1'b0;
         if (load) begin
            state_q    <= fdc_drive_pkg::scan_sector;
            sector_q   <= '0;
            byte_pos_q <= '0;
         end else if (byte_clk_q) begin
            if (byte_pos_q == fdc_drive_pkg::byte_cnt_t'(`MARK_BYTE)) begin
               if (state_q == fdc_drive_pkg::scan_sector)
                  header_clk_q <= 1'b1;
               else
                  ip_q <= 1'b1;
            end
            if (byte_pos_q == last_byte) begin
               byte_pos_q <= '0;
               case (state_q)
                  fdc_drive_pkg::scan_sector: begin
                     if (sector_q == last_sector) begin
                        sector_q <= '0;
                        state_q  <= fdc_drive_pkg::scan_gap;
                     end else begin
                        sector_q <= sector_q + 5'd1;
                     end
                  end
                  default: state_q <= fdc_drive_pkg::scan_sector;
               endcase
            end else begin
               byte_pos_q <= byte_pos_q + 9'd1;
            end
         end
      end
   end

   // The last drive has nobody behind it and answers with idle lines
   always_comb begin
      if (chain_end) begin
         byte_clk_tail   = 1'b0;
         header_clk_tail = 1'b0;
         ip_tail         = 1'b0;
         ds_tail         = 1'b0;
         ready_tail      = 1'b0;
         track_tail      = '0;
         sector_tail     = '0;
      end else begin
         byte_clk_tail   = byte_clk_next;
         header_clk_tail = header_clk_next;
         ip_tail         = ip_next;
         ds_tail         = ds_next;
         ready_tail      = ready_next;
         track_tail      = track_next;
         sector_tail     = sector_next;
      end
   end

   assign ready      = sel ? load_mounted : ready_tail;
   assign byte_clk   = sel ? byte_clk_q   : byte_clk_tail;
   assign header_clk = sel ? header_clk_q : header_clk_tail;
   assign ip         = sel ? ip_q         : ip_tail;
   assign ds         = sel ? load_ds      : ds_tail;
   assign track      = sel ? track_q      : track_tail;
   assign sector     = sel ? sector_q     : sector_tail;

endmodule

`default_nettype wire

// File: hdl/mount_regs.sv
`default_nettype none

`include "fdc_mock_cfg.svh"

module mount_regs (
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic                     wb_cyc,
   input  logic                     wb_stb,
   input  logic                     wb_we,
   input  fdc_bus_pkg::wb_addr_t    wb_adr,
   input  fdc_bus_pkg::wb_data_t    wb_dat_w,
   input  fdc_drive_pkg::track_t    head_track [`NUM_DRIVES],
   output fdc_bus_pkg::wb_data_t    wb_dat_r,
   output logic                     wb_ack,
   output logic [`NUM_DRIVES-1:0]   mounted,
   output logic [`NUM_DRIVES-1:0]   dbl_sided,
   output logic [`NUM_DRIVES-1:0]   dbl_density,
   output logic [`NUM_DRIVES-1:0]   load,
   output fdc_drive_pkg::sector_t   sps [`NUM_DRIVES]
);

   fdc_bus_pkg::drive_idx_t   drive_idx;
   fdc_bus_pkg::reg_sel_t     reg_sel;
   fdc_bus_pkg::mount_reg_t   wr_fields;
   fdc_bus_pkg::mount_reg_t   rd_mount;
   fdc_bus_pkg::wb_data_t     rd_data;
   logic                      addr_hit;
   logic                      req;
   logic                      wr_mount;

   // Each drive owns a pair of words, mount register first
   assign drive_idx = fdc_bus_pkg::drive_idx_t'(wb_adr >> 1);
   assign reg_sel   = fdc_bus_pkg::reg_sel_t'(wb_adr[0]);
   assign addr_hit  = int'(wb_adr >> 1) < `NUM_DRIVES;

   // A request is served on its first cycle, the ack blocks a second pass
   assign req       = wb_cyc && wb_stb && !wb_ack;
   assign wr_mount  = req && wb_we && addr_hit && (reg_sel == fdc_bus_pkg::reg_mount);
   assign wr_fields = fdc_bus_pkg::mount_reg_t'(wb_dat_w);

   always_comb begin
      rd_mount             = '0;
      rd_mount.mounted     = mounted[drive_idx];
      rd_mount.dbl_sided   = dbl_sided[drive_idx];
      rd_mount.dbl_density = dbl_density[drive_idx];
      rd_mount.sps         = sps[drive_idx];
      rd_data              = '0;
      if (addr_hit) begin
         if (reg_sel == fdc_bus_pkg::reg_mount)
            rd_data = fdc_bus_pkg::wb_data_t'(rd_mount);
         else
            rd_data = fdc_bus_pkg::wb_data_t'(head_track[drive_idx]);
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wb_ack      <= 1'b0;
         load        <= '0;
         mounted     <= '0;
         dbl_sided   <= '0;
         dbl_density <= '0;
         for (int i = 0; i < `NUM_DRIVES; i++)
            sps[i] <= '0;
      end else begin
         wb_ack <= req;
         load   <= '0;
         if (wr_mount) begin
            load[drive_idx]        <= 1'b1;
            mounted[drive_idx]     <= wr_fields.mounted;
            dbl_sided[drive_idx]   <= wr_fields.dbl_sided;
            dbl_density[drive_idx] <= wr_fields.dbl_density;
            sps[drive_idx]         <= wr_fields.sps;
         end
      end
   end

   // Read data is captured with the ack so it is stable while ack is high
   always_ff @(posedge clk) begin
      if (req)
         wb_dat_r <= rd_data;
   end

endmodule

`default_nettype wire

// File: hdl/mock_drive_chain.sv
`default_nettype none

`include "fdc_mock_cfg.svh"

module mock_drive_chain (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   wb_cyc,
   input  logic                   wb_stb,
   input  logic                   wb_we,
   input  fdc_bus_pkg::wb_addr_t  wb_adr,
   input  fdc_bus_pkg::wb_data_t  wb_dat_w,
   output fdc_bus_pkg::wb_data_t  wb_dat_r,
   output logic                   wb_ack,
   input  logic [`NUM_DRIVES-1:0] drive_sel,
   input  logic                   step,
   input  logic                   dir,
   output logic                   ready,
   output logic                   byte_clk,
   output logic                   header_clk,
   output logic                   ip,
   output logic                   ds,
   output fdc_drive_pkg::track_t  track,
   output fdc_drive_pkg::sector_t sector
);

   logic                    tick;
   logic [`NUM_DRIVES-1:0]  mounted;
   logic [`NUM_DRIVES-1:0]  dbl_sided;
   logic [`NUM_DRIVES-1:0]  dbl_density;
   logic [`NUM_DRIVES-1:0]  load;
   fdc_drive_pkg::sector_t  sps        [`NUM_DRIVES];
   fdc_drive_pkg::track_t   head_track [`NUM_DRIVES];

   // Chain taps, entry i is what drive i hands towards the controller
   logic [`NUM_DRIVES:0]    ch_ready;
   logic [`NUM_DRIVES:0]    ch_byte_clk;
   logic [`NUM_DRIVES:0]    ch_header_clk;
   logic [`NUM_DRIVES:0]    ch_ip;
   logic [`NUM_DRIVES:0]    ch_ds;
   fdc_drive_pkg::track_t   ch_track  [`NUM_DRIVES+1];
   fdc_drive_pkg::sector_t  ch_sector [`NUM_DRIVES+1];

   drive_timebase u_timebase (
      .clk    (clk),
      .arst_n (arst_n),
      .tick   (tick)
   );

   mount_regs u_regs (
      .clk         (clk),
      .arst_n      (arst_n),
      .wb_cyc      (wb_cyc),
      .wb_stb      (wb_stb),
      .wb_we       (wb_we),
      .wb_adr      (wb_adr),
      .wb_dat_w    (wb_dat_w),
      .head_track  (head_track),
      .wb_dat_r    (wb_dat_r),
      .wb_ack      (wb_ack),
      .mounted     (mounted),
      .dbl_sided   (dbl_sided),
      .dbl_density (dbl_density),
      .load        (load),
      .sps         (sps)
   );

   // Nothing sits behind the last drive
   assign ch_ready[`NUM_DRIVES]      = 1'b0;
   assign ch_byte_clk[`NUM_DRIVES]   = 1'b0;
   assign ch_header_clk[`NUM_DRIVES] = 1'b0;
   assign ch_ip[`NUM_DRIVES]         = 1'b0;
   assign ch_ds[`NUM_DRIVES]         = 1'b0;
   assign ch_track[`NUM_DRIVES]      = '0;
   assign ch_sector[`NUM_DRIVES]     = '0;

   for (genvar i = 0; i < `NUM_DRIVES; i++) begin : g_drive
      mock_drive #(
         .chain_end (i == `NUM_DRIVES - 1)
      ) u_drive (
         .clk             (clk),
         .arst_n          (arst_n),
         .tick            (tick),
         .sel             (drive_sel[i]),
         .step            (step),
         .dir             (dir),
         .byte_clk_next   (ch_byte_clk[i+1]),
         .header_clk_next (ch_header_clk[i+1]),
         .ip_next         (ch_ip[i+1]),
         .ds_next         (ch_ds[i+1]),
         .ready_next      (ch_ready[i+1]),
         .track_next      (ch_track[i+1]),
         .sector_next     (ch_sector[i+1]),
         .load            (load[i]),
         .load_mounted    (mounted[i]),
         .load_ds         (dbl_sided[i]),
         .load_dd         (dbl_density[i]),
         .load_sps        (sps[i]),
         .ready           (ch_ready[i]),
         .byte_clk        (ch_byte_clk[i]),
         .header_clk      (ch_header_clk[i]),
         .ip              (ch_ip[i]),
         .ds              (ch_ds[i]),
         .track           (ch_track[i]),
         .sector          (ch_sector[i]),
         .head_track      (head_track[i])
      );
   end

   assign ready      = ch_ready[0];
   assign byte_clk   = ch_byte_clk[0];
   assign header_clk = ch_header_clk[0];
   assign ip         = ch_ip[0];
   assign ds         = ch_ds[0];
   assign track      = ch_track[0];
   assign sector     = ch_sector[0];

endmodule

`default_nettype wire

// File: dv/tb_mock_drive_chain.sv
`default_nettype none

`include "fdc_mock_cfg.svh"

module tb_mock_drive_chain;

   localparam int     CLK_PERIOD  = 20;
   localparam int     TICK_CYCLES = `CLK_HZ / `DRIVE_HZ;
   localparam int     SD_BYTE_CYC = (`SD_BYTE_ENABLES + 1) * TICK_CYCLES;
   localparam int     DD_BYTE_CYC = (`DD_BYTE_ENABLES + 1) * TICK_CYCLES;
   localparam int     SCAN_BYTES  = 4 * `DD_SECTOR_BYTES + `DD_GAP_BYTES + 3 * `MARK_BYTE + 8;
   localparam longint TEST_CYCLES = 8 * SD_BYTE_CYC + 4 * DD_BYTE_CYC
                                    + longint'(SCAN_BYTES) * DD_BYTE_CYC + 20000;
   localparam longint WATCHDOG_TIME = 2 * TEST_CYCLES * CLK_PERIOD;

   logic                   clk;
   logic                   arst_n;
   logic                   wb_cyc;
   logic                   wb_stb;
   logic                   wb_we;
   fdc_bus_pkg::wb_addr_t  wb_adr;
   fdc_bus_pkg::wb_data_t  wb_dat_w;
   fdc_bus_pkg::wb_data_t  wb_dat_r;
   logic                   wb_ack;
   logic [`NUM_DRIVES-1:0] drive_sel;
   logic                   step;
   logic                   dir;
   logic                   ready;
   logic                   byte_clk;
   logic                   header_clk;
   logic                   ip;
   logic                   ds;
   fdc_drive_pkg::track_t  track;
   fdc_drive_pkg::sector_t sector;

   logic [31:0] lcg_state;

   // Per-drive model of head position and mount fields
   int m_track   [`NUM_DRIVES];
   bit m_mounted [`NUM_DRIVES];
   bit m_ds      [`NUM_DRIVES];
   bit m_dd      [`NUM_DRIVES];
   int m_sps     [`NUM_DRIVES];

   // Sector scan model of the selected drive
   bit sc_in_gap;
   bit sc_dd;
   bit exp_hdr;
   bit exp_ip;
   int sc_sector;
   int sc_pos;
   int sc_sps;
   int bytes_seen;
   int hdr_seen;
   int ip_seen;

   mock_drive_chain DUT (
      .clk        (clk),
      .arst_n     (arst_n),
      .wb_cyc     (wb_cyc),
      .wb_stb     (wb_stb),
      .wb_we      (wb_we),
      .wb_adr     (wb_adr),
      .wb_dat_w   (wb_dat_w),
      .wb_dat_r   (wb_dat_r),
      .wb_ack     (wb_ack),
      .drive_sel  (drive_sel),
      .step       (step),
      .dir        (dir),
      .ready      (ready),
      .byte_clk   (byte_clk),
      .header_clk (header_clk),
      .ip         (ip),
      .ds         (ds),
      .track      (track),
      .sector     (sector)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state >> 8;
   endfunction

   // Mount register layout from the register map
   function automatic fdc_bus_pkg::wb_data_t mount_word(bit mnt, bit dsd, bit ddn, int sps_val);
      return fdc_bus_pkg::wb_data_t'((sps_val % 32) << 8) | {13'd0, ddn, dsd, mnt};
   endfunction

   task automatic stop_run();
      $display("Checks failed");
      $fatal(1);
   endtask

   task automatic report_error(input string what);
      $display("Error at time %0t: %s", $time, what);
      stop_run();
   endtask

   task automatic check_track(input string name, input fdc_drive_pkg::track_t got,
                              input fdc_drive_pkg::track_t exp);
      if (got !== exp) begin
         $display("Mismatch at time %0t: %s is %0d, expected %0d", $time, name, got, exp);
         stop_run();
      end
   endtask

   task automatic check_sector(input string name, input fdc_drive_pkg::sector_t got,
                               input fdc_drive_pkg::sector_t exp);
      if (got !== exp) begin
         $display("Mismatch at time %0t: %s is %0d, expected %0d", $time, name, got, exp);
         stop_run();
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("Mismatch at time %0t: %s is %b, expected %b", $time, name, got, exp);
         stop_run();
      end
   endtask

   task automatic check_data(input string name, input fdc_bus_pkg::wb_data_t got,
                             input fdc_bus_pkg::wb_data_t exp);
      if (got !== exp) begin
         $display("Mismatch at time %0t: %s is %h, expected %h", $time, name, got, exp);
         stop_run();
      end
   endtask

   task automatic check_count(input string name, input fdc_drive_pkg::enable_cnt_t got,
                              input fdc_drive_pkg::enable_cnt_t exp);
      if (got !== exp) begin
         $display("Mismatch at time %0t: %s is %0d, expected %0d", $time, name, got, exp);
         stop_run();
      end
   endtask

   // The ack of a classic cycle must follow the request by exactly one clock
   task automatic wb_access(input logic we, input fdc_bus_pkg::wb_addr_t adr,
                            input fdc_bus_pkg::wb_data_t wdata,
                            output fdc_bus_pkg::wb_data_t rdata);
      int waited;
      waited = 0;
      @(posedge clk);
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      wb_we    <= we;
      wb_adr   <= adr;
      wb_dat_w <= wdata;
      @(negedge clk);
      while (!wb_ack && waited < 16) begin
         @(negedge clk);
         waited++;
      end
      if (!wb_ack)
         report_error("wb_ack never came for a bus request");
      if (waited != 1)
         report_error($sformatf("wb_ack came %0d cycles after the request", waited));
      rdata = wb_dat_r;
      @(posedge clk);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
   endtask

   task automatic wb_write(input int adr, input fdc_bus_pkg::wb_data_t data);
      fdc_bus_pkg::wb_data_t unused;
      wb_access(1'b1, fdc_bus_pkg::wb_addr_t'(adr), data, unused);
   endtask

   task automatic wb_read(input int adr, output fdc_bus_pkg::wb_data_t data);
      wb_access(1'b0, fdc_bus_pkg::wb_addr_t'(adr), '0, data);
   endtask

   task automatic write_mount(input int d, input fdc_bus_pkg::wb_data_t value);
      m_mounted[d] = value[0];
      m_ds[d]      = value[1];
      m_dd[d]      = value[2];
      m_sps[d]     = int'(value[12:8]);
      wb_write(2 * d, value);
   endtask

   task automatic select_drive(input int d);
      logic [`NUM_DRIVES-1:0] word;
      word = '0;
      if (d >= 0 && d < `NUM_DRIVES)
         word[d] = 1'b1;
      @(posedge clk);
      drive_sel <= word;
   endtask

   // The head moves in the cycle after the falling edge of step
   task automatic pulse_step(input int d, input logic inward);
      @(posedge clk);
      step <= 1'b1;
      dir  <= inward;
      @(posedge clk);
      step <= 1'b0;
      @(negedge clk);
      check_track("track before the step lands", track, fdc_drive_pkg::track_t'(m_track[d]));
      if (inward && m_track[d] < `MAX_TRACK)
         m_track[d]++;
      else if (!inward && m_track[d] > 0)
         m_track[d]--;
      @(negedge clk);
      check_track("track", track, fdc_drive_pkg::track_t'(m_track[d]));
   endtask

   task automatic wait_byte_clk();
      int cycles;
      cycles = 0;
      @(negedge clk);
      while (!byte_clk && cycles < SD_BYTE_CYC + 64) begin
         @(negedge clk);
         cycles++;
      end
      if (!byte_clk)
         report_error("a mounted drive produced no byte_clk");
   endtask

   task automatic measure_byte_rate(input int d, input bit dd);
      int ticks;
      int cycles;
      fdc_drive_pkg::enable_cnt_t exp_ticks;
      exp_ticks = dd ? fdc_drive_pkg::enable_cnt_t'(`DD_BYTE_ENABLES + 1)
                     : fdc_drive_pkg::enable_cnt_t'(`SD_BYTE_ENABLES + 1);
      select_drive(d);
      write_mount(d, mount_word(1'b1, 1'b0, dd, 2));
      wait_byte_clk();
      for (int k = 0; k < 2; k++) begin
         ticks  = 0;
         cycles = 0;
         do begin
            @(negedge clk);
            if (DUT.tick)
               ticks++;
            cycles++;
         end while (!byte_clk && cycles < SD_BYTE_CYC + 64);
         if (!byte_clk)
            report_error("byte_clk stopped on a mounted drive");
         check_count("tick pulses per byte_clk period", fdc_drive_pkg::enable_cnt_t'(ticks),
                     exp_ticks);
      end
   endtask

   // Advances the model by one clock and checks marks one cycle after their byte_clk
   task automatic step_scan();
      int last;
      @(negedge clk);
      check_sector("sector", sector, fdc_drive_pkg::sector_t'(sc_sector));
      check_bit("header_clk", header_clk, exp_hdr);
      check_bit("ip", ip, exp_ip);
      if (header_clk)
         hdr_seen++;
      if (ip)
         ip_seen++;
      exp_hdr = 1'b0;
      exp_ip  = 1'b0;
      if (byte_clk) begin
         bytes_seen++;
         if (sc_pos == `MARK_BYTE) begin
            if (sc_in_gap)
               exp_ip = 1'b1;
            else
               exp_hdr = 1'b1;
         end
         if (sc_in_gap)
            last = sc_dd ? `DD_GAP_BYTES - 1 : `SD_GAP_BYTES - 1;
         else
            last = sc_dd ? `DD_SECTOR_BYTES - 1 : `SD_SECTOR_BYTES - 1;
         if (sc_pos == last) begin
            sc_pos = 0;
            if (sc_in_gap) begin
               sc_in_gap = 1'b0;
            end else if (sc_sector == sc_sps - 1) begin
               sc_sector = 0;
               sc_in_gap = 1'b1;
            end else begin
               sc_sector++;
            end
         end else begin
            sc_pos++;
         end
      end
   endtask

   // Starts right after a mount write, when the drive has just cleared its counters
   task automatic run_scan(input int n_bytes, input int sps_val, input bit dd);
      sc_in_gap  = 1'b0;
      sc_dd      = dd;
      exp_hdr    = 1'b0;
      exp_ip     = 1'b0;
      sc_sector  = 0;
      sc_pos     = 0;
      sc_sps     = sps_val;
      bytes_seen = 0;
      hdr_seen   = 0;
      ip_seen    = 0;
      while (bytes_seen < n_bytes)
         step_scan();
      step_scan();
   endtask

   initial begin
      #(WATCHDOG_TIME);
      report_error("simulation timed out before the tests finished");
   end

   initial begin
      logic [31:0]           r;
      fdc_bus_pkg::wb_data_t rd;
      int                    sps_a;
      int                    pick;

      lcg_state   = 32'hd543;
      arst_n      = 1'b0;
      wb_cyc      = 1'b0;
      wb_stb      = 1'b0;
      wb_we       = 1'b0;
      wb_adr      = '0;
      wb_dat_w    = '0;
      drive_sel   = '0;
      step        = 1'b0;
      dir         = 1'b0;
      for (int d = 0; d < `NUM_DRIVES; d++) begin
         m_track[d]   = 0;
         m_mounted[d] = 1'b0;
         m_ds[d]      = 1'b0;
         m_dd[d]      = 1'b0;
         m_sps[d]     = 0;
      end
      repeat (3) @(posedge clk);
      arst_n <= 1'b1;

      @(negedge clk);
      check_bit("ready", ready, 1'b0);
      check_bit("byte_clk", byte_clk, 1'b0);
      check_bit("header_clk", header_clk, 1'b0);
      check_bit("ip", ip, 1'b0);
      check_bit("wb_ack", wb_ack, 1'b0);
      for (int d = 0; d < `NUM_DRIVES; d++) begin
         select_drive(d);
         @(negedge clk);
         check_bit("ready", ready, 1'b0);
         check_track("track", track, '0);
         wb_read(2 * d + 1, rd);
         check_data("track register", rd, '0);
         wb_read(2 * d, rd);
         check_data("mount register", rd, '0);
      end

      for (int d = 0; d < `NUM_DRIVES; d++) begin
         r = next_rand();
         write_mount(d, r[15:0]);
      end
      for (int d = 0; d < `NUM_DRIVES; d++) begin
         wb_read(2 * d, rd);
         check_data("mount register", rd, mount_word(m_mounted[d], m_ds[d], m_dd[d], m_sps[d]));
      end
      if (2 * `NUM_DRIVES < 16) begin
         r = next_rand();
         pick = 2 * `NUM_DRIVES + int'(r % (16 - 2 * `NUM_DRIVES));
         wb_write(pick, r[15:0]);
         wb_read(pick, rd);
         check_data("unused register", rd, '0);
      end

      // Each drive is pushed into both clamps before its random walk
      for (int d = 0; d < `NUM_DRIVES; d++) begin
         select_drive(d);
         pulse_step(d, 1'b0);
         repeat (`MAX_TRACK + 1)
            pulse_step(d, 1'b1);
         repeat (40) begin
            r = next_rand();
            pulse_step(d, r[12]);
         end
         for (int e = 0; e < `NUM_DRIVES; e++) begin
            wb_read(2 * e + 1, rd);
            check_data("track register", rd, fdc_bus_pkg::wb_data_t'(m_track[e]));
         end
      end

      measure_byte_rate(1, 1'b0);
      measure_byte_rate(1, 1'b1);
      select_drive(3);
      write_mount(3, mount_word(1'b0, 1'b1, 1'b0, 2));
      repeat (2 * SD_BYTE_CYC) begin
         @(negedge clk);
         check_bit("byte_clk of an unmounted drive", byte_clk, 1'b0);
         check_bit("ready of an unmounted drive", ready, 1'b0);
      end

      select_drive(2);
      r = next_rand();
      sps_a = 1 + int'(r % 3);
      write_mount(2, mount_word(1'b1, r[4], 1'b1, sps_a));
      run_scan(sps_a * `DD_SECTOR_BYTES + `DD_GAP_BYTES + `MARK_BYTE + 1, sps_a, 1'b1);
      check_count("header_clk pulses", fdc_drive_pkg::enable_cnt_t'(hdr_seen),
                  fdc_drive_pkg::enable_cnt_t'(sps_a + 1));
      check_count("ip pulses", fdc_drive_pkg::enable_cnt_t'(ip_seen), 8'd1);
      write_mount(2, mount_word(1'b1, 1'b0, 1'b1, 3));
      run_scan(`DD_SECTOR_BYTES + `MARK_BYTE + 1, 3, 1'b1);
      r = next_rand();
      sps_a = 1 + int'(r % 3);
      write_mount(2, mount_word(1'b1, 1'b1, 1'b1, sps_a));
      run_scan(`MARK_BYTE + 4, sps_a, 1'b1);

      for (int d = 0; d < `NUM_DRIVES; d++) begin
         r = next_rand();
         write_mount(d, r[15:0]);
      end
      repeat (24) begin
         r = next_rand();
         pick = int'(r % (`NUM_DRIVES + 1));
         select_drive(pick);
         repeat (3) begin
            @(negedge clk);
            if (pick < `NUM_DRIVES) begin
               check_bit("ready", ready, m_mounted[pick]);
               check_bit("ds", ds, m_ds[pick]);
               check_track("track", track, fdc_drive_pkg::track_t'(m_track[pick]));
            end else begin
               check_bit("byte_clk", byte_clk, 1'b0);
               check_bit("header_clk", header_clk, 1'b0);
               check_bit("ip", ip, 1'b0);
               check_bit("ready", ready, 1'b0);
               check_bit("ds", ds, 1'b0);
               check_track("track", track, '0);
               check_sector("sector", sector, '0);
            end
         end
      end

      $display("All checks passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: compile.f
+incdir+hdl
hdl/fdc_drive_pkg.sv
hdl/fdc_bus_pkg.sv
hdl/drive_timebase.sv
hdl/mock_drive.sv
hdl/mount_regs.sv
hdl/mock_drive_chain.sv
dv/tb_mock_drive_chain.sv

// File: Bender.yml
package:
  name: mock_drive_chain

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/fdc_drive_pkg.sv
      - hdl/fdc_bus_pkg.sv
      - hdl/drive_timebase.sv
      - hdl/mock_drive.sv
      - hdl/mount_regs.sv
      - hdl/mock_drive_chain.sv

  - target: test
    include_dirs:
      - hdl
    files:
      - dv/tb_mock_drive_chain.sv
